/* vlog.f */
verilog/starforce_pkg.sv
verilog/pixel_clock_gen.sv
verilog/fetch_sequencer.sv
verilog/plane_shifter.sv
verilog/layer_mixer.sv
verilog/starforce_pixel_path.sv
testbench/tb_starforce_pixel_path.sv

/* Makefile */
TOP := tb_starforce_pixel_path

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -o sim -f vlog.f

run: compile
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/tb_starforce_pixel_path.sv */
// self-checking testbench; the byte source answers every fetch_o at once, so no deadline is missed
`timescale 1ns/1ps
`default_nettype none

module tb_starforce_pixel_path;

   import starforce_pkg::*;

   localparam int BYTE_CYCLES = CLK_DIV * PIXELS_PER_BYTE;

   logic       clk;
   logic       CR;
   logic       run_i;
   logic       flip_i;
   logic [7:0] fg_plane0_i;
   logic [7:0] fg_plane1_i;
   logic [7:0] bg_plane0_i;
   logic [7:0] bg_plane1_i;
   logic       fetch_o;
   logic       pixel_strobe_o;
   logic [2:0] pixel_o;
   layer_t     layer_o;

   // expected pixels as {layer, pixel}, oldest first
   logic [4:0] ref_q[$];
   logic [2:0] exp_pix;
   layer_t     exp_layer;
   logic       exp_avail;
   logic       started;
   logic       fg_off;
   integer     seed;
   int         errors;
   int         timeouts;

   // bookkeeping for the timing checks
   int         gap;
   int         strobes_since_fetch;
   int         idle_cycles;
   logic       strobe_seen;
   logic       fetch_seen;

   starforce_pixel_path u_starforce_pixel_path (
      .clk            (clk),
      .CR             (CR),
      .run_i          (run_i),
      .flip_i         (flip_i),
      .fg_plane0_i    (fg_plane0_i),
      .fg_plane1_i    (fg_plane1_i),
      .bg_plane0_i    (bg_plane0_i),
      .bg_plane1_i    (bg_plane1_i),
      .fetch_o        (fetch_o),
      .pixel_strobe_o (pixel_strobe_o),
      .pixel_o        (pixel_o),
      .layer_o        (layer_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ========================================
   // reference model
   // ========================================

   // fg wins unless transparent, then bg, else colour 0
   function automatic logic [4:0] mix_pixel(input logic [1:0] fg, input logic [1:0] bg);
      logic [4:0] r;
      if (fg != 2'b00)
         r = {LAYER_FG, 1'b1, fg};
      else if (bg != 2'b00)
         r = {LAYER_BG, 1'b0, bg};
      else
         r = {LAYER_NONE, 3'b000};
      return r;
   endfunction

   // bytes just loaded, in the order set by flip at the load
   task automatic push_byte();
      logic [2:0] b;
      for (int k = 0; k < PIXELS_PER_BYTE; k++)
      begin
         b = flip_i ? 3'(k) : 3'(7 - k);
         ref_q.push_back(mix_pixel({fg_plane1_i[b], fg_plane0_i[b]},
                                   {bg_plane1_i[b], bg_plane0_i[b]}));
      end
   endtask

   task automatic take_expected();
      logic [4:0] f;
      exp_avail = (ref_q.size() > 0);
      if (exp_avail)
      begin
         f         = ref_q.pop_front();
         exp_pix   = f[2:0];
         exp_layer = layer_t'(f[4:3]);
      end
   endtask

   task automatic present_bytes();
      bg_plane0_i = 8'($random(seed));
      bg_plane1_i = 8'($random(seed));
      fg_plane0_i = fg_off ? 8'h00 : 8'($random(seed));
      fg_plane1_i = fg_off ? 8'h00 : 8'($random(seed));
   endtask

   // one clk, then look at the new outputs
   task automatic step();
      @(posedge clk);
      #1;
      if (pixel_strobe_o)
         take_expected();
   endtask

   task automatic stream_bytes(input int n_bytes, input int flip_at);
      int got;
      int cycles;
      got    = 0;
      cycles = 0;
      while (got < n_bytes && cycles < n_bytes * BYTE_CYCLES + 4 * CLK_DIV)
      begin
         step();
         cycles++;
         if (fetch_o)
         begin
            push_byte();
            present_bytes();
            got++;
         end
         if (cycles == flip_at)
            flip_i = 1'b1;
      end
      if (got < n_bytes)
      begin
         timeouts++;
         $display("timeout at %0t: only %0d of %0d fetch_o pulses came", $time, got, n_bytes);
      end
   endtask

   always @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         gap                 <= 0;
         strobes_since_fetch <= 0;
         idle_cycles         <= 0;
         strobe_seen         <= 1'b0;
         fetch_seen          <= 1'b0;
      end
      else
      begin
         gap                 <= pixel_strobe_o ? 1 : gap + 1;
         strobes_since_fetch <= fetch_o ? 0 : strobes_since_fetch + (pixel_strobe_o ? 1 : 0);
         idle_cycles         <= run_i ? 0 : idle_cycles + 1;
         strobe_seen         <= run_i && (strobe_seen || pixel_strobe_o);
         fetch_seen          <= run_i && (fetch_seen || fetch_o);
      end
   end

   // ========================================
   // checks
   // ========================================

   quiet_before_run: assert property (@(posedge clk) disable iff (!CR)
      !started |-> !fetch_o && !pixel_strobe_o && pixel_o == 3'b000 && layer_o == LAYER_NONE)
   else
   begin
      errors++;
      $display("error at %0t: fetch_o=%0b pixel_strobe_o=%0b pixel_o=%0d layer_o=%0d, want 0",
               $time, $sampled(fetch_o), $sampled(pixel_strobe_o), $sampled(pixel_o),
               $sampled(layer_o));
   end

   strobe_has_ref: assert property (@(posedge clk) disable iff (!CR)
      pixel_strobe_o |-> exp_avail)
   else
   begin
      errors++;
      $display("strobe at %0t with no pixel left in the reference queue", $time);
   end

   pixel_value: assert property (@(posedge clk) disable iff (!CR)
      pixel_strobe_o && exp_avail |-> pixel_o == exp_pix)
   else
   begin
      errors++;
      $display("error at %0t: pixel_o = %0d, expected %0d", $time, $sampled(pixel_o),
               $sampled(exp_pix));
   end

   layer_value: assert property (@(posedge clk) disable iff (!CR)
      pixel_strobe_o && exp_avail |-> layer_o == exp_layer)
   else
   begin
      errors++;
      $display("error at %0t: layer_o = %0d, expected %0d", $time, $sampled(layer_o),
               $sampled(exp_layer));
   end

   strobe_spacing: assert property (@(posedge clk) disable iff (!CR)
      pixel_strobe_o && strobe_seen |-> gap == CLK_DIV)
   else
   begin
      errors++;
      $display("error at %0t: strobe gap = %0d, expected %0d", $time, $sampled(gap), CLK_DIV);
   end

   // the 8th strobe of a byte lands with the fetch
   fetch_per_byte: assert property (@(posedge clk) disable iff (!CR)
      fetch_o && fetch_seen |-> pixel_strobe_o && strobes_since_fetch == PIXELS_PER_BYTE - 1)
   else
   begin
      errors++;
      $display("error at %0t: strobes per fetch = %0d, expected %0d", $time,
               $sampled(strobes_since_fetch) + 1, PIXELS_PER_BYTE);
   end

   stopped_quiet: assert property (@(posedge clk) disable iff (!CR)
      idle_cycles > CLK_DIV |-> !pixel_strobe_o && !fetch_o)
   else
   begin
      errors++;
      $display("output pulse at %0t although run_i has been low for %0d cycles", $time,
               $sampled(idle_cycles));
   end

   // ========================================
   // stimulus
   // ========================================

   initial
   begin
      seed        = 32'he0de53c5;
      CR          = 1'b0;
      run_i       = 1'b0;
      flip_i      = 1'b0;
      fg_plane0_i = 8'h00;
      fg_plane1_i = 8'h00;
      bg_plane0_i = 8'h00;
      bg_plane1_i = 8'h00;
      exp_pix     = 3'b000;
      exp_layer   = LAYER_NONE;
      exp_avail   = 1'b0;
      started     = 1'b0;
      fg_off      = 1'b1;
      errors      = 0;
      timeouts    = 0;
      repeat (4) @(posedge clk);
      #1;
      CR = 1'b1;
      repeat (20) step();

      // background only, bit 7 first
      present_bytes();
      started = 1'b1;
      run_i   = 1'b1;
      stream_bytes(6, -1);

      // all planes random, flip raised in the middle of the fourth byte
      fg_off = 1'b0;
      stream_bytes(10, 3 * BYTE_CYCLES + 30);

      // stop, then restart on fresh bytes
      run_i = 1'b0;
      repeat (2 * CLK_DIV) step();
      ref_q.delete();
      present_bytes();
      run_i = 1'b1;
      stream_bytes(4, -1);
      run_i = 1'b0;
      repeat (2 * CLK_DIV) step();

      $display("check errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/starforce_pixel_path.sv */
// pixel path top; single clock, bytes must be valid before run_i rises and within 63 clk of fetch_o
`timescale 1ns/1ps
`default_nettype none

module starforce_pixel_path (
   input  logic                             clk,
   input  logic                             CR,
   input  logic                             run_i,
   input  logic                             flip_i,
   input  logic [starforce_pkg::BYTE_W-1:0] fg_plane0_i,
   input  logic [starforce_pkg::BYTE_W-1:0] fg_plane1_i,
   input  logic [starforce_pkg::BYTE_W-1:0] bg_plane0_i,
   input  logic [starforce_pkg::BYTE_W-1:0] bg_plane1_i,
   output logic                             fetch_o,
   output logic                             pixel_strobe_o,
   output logic [2:0]                       pixel_o,
   output starforce_pkg::layer_t            layer_o
);

   import starforce_pkg::*;

   logic        count_en;
   logic        pix_cen;
   logic        byte_last;
   logic        shift_en;
   shift_mode_t shift_mode;
   logic        shift_dir;
   logic        fg_pix0;
   logic        fg_pix1;
   logic        bg_pix0;
   logic        bg_pix1;

   // ========================================
   // timing and control
   // ========================================

   pixel_clock_gen u_pixel_clock_gen (
      .clk         (clk),
      .CR          (CR),
      .count_en_i  (count_en),
      .pix_cen_o   (pix_cen),
      .byte_last_o (byte_last)
   );

   fetch_sequencer u_fetch_sequencer (
      .clk          (clk),
      .CR           (CR),
      .run_i        (run_i),
      .flip_i       (flip_i),
      .pix_cen_i    (pix_cen),
      .byte_last_i  (byte_last),
      .count_en_o   (count_en),
      .shift_en_o   (shift_en),
      .shift_mode_o (shift_mode),
      .shift_dir_o  (shift_dir),
      .fetch_o      (fetch_o)
   );

   // ========================================
   // bitplane shifters
   // ========================================

   plane_shifter u_fg0 (
      .clk        (clk),
      .CR         (CR),
      .shift_en_i (shift_en),
      .mode_i     (shift_mode),
      .dir_i      (shift_dir),
      .byte_i     (fg_plane0_i),
      .pix_o      (fg_pix0)
   );

   plane_shifter u_fg1 (
      .clk        (clk),
      .CR         (CR),
      .shift_en_i (shift_en),
      .mode_i     (shift_mode),
      .dir_i      (shift_dir),
      .byte_i     (fg_plane1_i),
      .pix_o      (fg_pix1)
   );

   plane_shifter u_bg0 (
      .clk        (clk),
      .CR         (CR),
      .shift_en_i (shift_en),
      .mode_i     (shift_mode),
      .dir_i      (shift_dir),
      .byte_i     (bg_plane0_i),
      .pix_o      (bg_pix0)
   );

   plane_shifter u_bg1 (
      .clk        (clk),
      .CR         (CR),
      .shift_en_i (shift_en),
      .mode_i     (shift_mode),
      .dir_i      (shift_dir),
      .byte_i     (bg_plane1_i),
      .pix_o      (bg_pix1)
   );

   // fg over bg
   layer_mixer u_layer_mixer (
      .clk            (clk),
      .CR             (CR),
      .pix_cen_i      (pix_cen),
      .fg_pix0_i      (fg_pix0),
      .fg_pix1_i      (fg_pix1),
      .bg_pix0_i      (bg_pix0),
      .bg_pix1_i      (bg_pix1),
      .pixel_o        (pixel_o),
      .layer_o        (layer_o),
      .pixel_strobe_o (pixel_strobe_o)
   );

endmodule

`default_nettype wire

/* verilog/layer_mixer.sv */
// two-layer priority mixer; colour 0 is transparent on both layers, no palette lookup
`timescale 1ns/1ps
`default_nettype none

module layer_mixer (
   input  logic                  clk,
   input  logic                  CR,
   input  logic                  pix_cen_i,
   input  logic                  fg_pix0_i,
   input  logic                  fg_pix1_i,
   input  logic                  bg_pix0_i,
   input  logic                  bg_pix1_i,
   output logic [2:0]            pixel_o,
   output starforce_pkg::layer_t layer_o,
   output logic                  pixel_strobe_o
);

   import starforce_pkg::*;

   logic [1:0] fg;
   logic [1:0] bg;
   logic [2:0] pixel_nxt;
   layer_t     layer_nxt;

   assign fg = {fg_pix1_i, fg_pix0_i};
   assign bg = {bg_pix1_i, bg_pix0_i};

   // ========================================
   // priority select
   // ========================================

   always_comb
   begin
      if (fg != 2'b00)
      begin
         pixel_nxt = {1'b1, fg};
         layer_nxt = LAYER_FG;
      end
      else if (bg != 2'b00)
      begin
         pixel_nxt = {1'b0, bg};
         layer_nxt = LAYER_BG;
      end
      else
      begin
         pixel_nxt = 3'b000;
         layer_nxt = LAYER_NONE;
      end
   end

   // sample on the pixel enable, strobe marks the first cycle of the new value
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         pixel_o        <= 3'b000;
         layer_o        <= LAYER_NONE;
         pixel_strobe_o <= 1'b0;
      end
      else
      begin
         if (pix_cen_i)
         begin
            pixel_o <= pixel_nxt;
            layer_o <= layer_nxt;
         end
         pixel_strobe_o <= pix_cen_i;
      end
   end

   a_none_iff_zero: assert property (@(posedge clk) disable iff (!CR)
      (layer_o == LAYER_NONE) == (pixel_o == 3'b000));

endmodule

`default_nettype wire

/* verilog/plane_shifter.sv */
// 74194-style 8 bit shifter; serial fill is always 0, CR clears the register like the part
`timescale 1ns/1ps
`default_nettype none

module plane_shifter (
   input  logic                             clk,
   input  logic                             CR,
   input  logic                             shift_en_i,
   input  starforce_pkg::shift_mode_t       mode_i,
   input  logic                             dir_i,
   input  logic [starforce_pkg::BYTE_W-1:0] byte_i,
   output logic                             pix_o
);

   import starforce_pkg::*;

   logic [BYTE_W-1:0] q;

   // ========================================
   // universal shift register
   // ========================================

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         q <= '0;
      end
      else if (shift_en_i)
      begin
         case (mode_i)
            MODE_LOAD: q <= byte_i;
            // toward bit 7, fill at bit 0
            MODE_SHL:  q <= {q[BYTE_W-2:0], 1'b0};
            // toward bit 0, fill at bit 7
            MODE_SHR:  q <= {1'b0, q[BYTE_W-1:1]};
            default:   q <= q;
         endcase
      end
   end

   // serial tap follows the shift direction
   assign pix_o = dir_i ? q[0] : q[BYTE_W-1];

   // the sequencer drops the enable instead of asking for a hold
   a_no_hold_enabled: assert property (@(posedge clk) disable iff (!CR)
      shift_en_i |-> (mode_i != MODE_HOLD));

endmodule

`default_nettype wire

/* verilog/fetch_sequencer.sv */
// byte fetch FSM; no back-pressure, a late source simply gets its stale bytes reloaded
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer (
   input  logic                       clk,
   input  logic                       CR,
   input  logic                       run_i,
   input  logic                       flip_i,
   input  logic                       pix_cen_i,
   input  logic                       byte_last_i,
   output logic                       count_en_o,
   output logic                       shift_en_o,
   output starforce_pkg::shift_mode_t shift_mode_o,
   output logic                       shift_dir_o,
   output logic                       fetch_o
);

   import starforce_pkg::*;

   seq_state_t state;
   seq_state_t state_nxt;
   logic       load;
   logic       shift;

   // ========================================
   // state register
   // ========================================

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         state <= SEQ_IDLE;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   always_comb
   begin
      state_nxt = state;
      if (!run_i)
      begin
         state_nxt = SEQ_IDLE;
      end
      else
      begin
         case (state)
            SEQ_IDLE:  state_nxt = SEQ_PRIME;
            SEQ_PRIME: state_nxt = SEQ_RUN;
            SEQ_RUN:   state_nxt = SEQ_RUN;
            default:   state_nxt = SEQ_IDLE;
         endcase
      end
   end

   // ========================================
   // shifter control
   // ========================================

   // prime cycle loads the first bytes, then one load per byte boundary
   assign load  = (state == SEQ_PRIME) || ((state == SEQ_RUN) && pix_cen_i && byte_last_i);
   assign shift = (state == SEQ_RUN) && pix_cen_i && !byte_last_i;

   assign count_en_o = (state == SEQ_RUN);
   assign shift_en_o = load || shift;

   always_comb
   begin
      if (load)
      begin
         shift_mode_o = MODE_LOAD;
      end
      else if (shift)
      begin
         // direction of the byte in flight, not of flip_i
         shift_mode_o = shift_dir_o ? MODE_SHR : MODE_SHL;
      end
      else
      begin
         shift_mode_o = MODE_HOLD;
      end
   end

   // flip takes effect from the byte being loaded
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         shift_dir_o <= 1'b0;
         fetch_o     <= 1'b0;
      end
      else
      begin
         if (load)
         begin
            shift_dir_o <= flip_i;
         end
         fetch_o <= load;
      end
   end

   a_fetch_single: assert property (@(posedge clk) disable iff (!CR)
      fetch_o |=> !fetch_o);

   a_fetch_after_load: assert property (@(posedge clk) disable iff (!CR)
      fetch_o |-> $past(shift_en_o && (shift_mode_o == MODE_LOAD)));

endmodule

`default_nettype wire

/* verilog/pixel_clock_gen.sv */
// pixel enable timer; both counters sit at 0 whenever count_en_i is low, no free-running mode
`timescale 1ns/1ps
`default_nettype none

module pixel_clock_gen (
   input  logic clk,
   input  logic CR,
   input  logic count_en_i,
   output logic pix_cen_o,
   output logic byte_last_o
);

   import starforce_pkg::*;

   logic [DIV_W-1:0] div_cnt;
   logic [PIX_W-1:0] pix_cnt;
   logic             div_last;

   // ========================================
   // clk divider
   // ========================================

   assign div_last = (div_cnt == DIV_W'(CLK_DIV - 1));

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         div_cnt <= '0;
      end
      else if (!count_en_i)
      begin
         div_cnt <= '0;
      end
      else if (div_last)
      begin
         div_cnt <= '0;
      end
      else
      begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // one clk wide, on the last count of each period
   assign pix_cen_o = count_en_i && div_last;

   // ========================================
   // pixel position inside the byte
   // ========================================

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         pix_cnt <= '0;
      end
      else if (!count_en_i)
      begin
         pix_cnt <= '0;
      end
      else if (pix_cen_o)
      begin
         if (byte_last_o)
         begin
            pix_cnt <= '0;
         end
         else
         begin
            pix_cnt <= pix_cnt + 1'b1;
         end
      end
   end

   assign byte_last_o = (pix_cnt == PIX_W'(PIXELS_PER_BYTE - 1));

   // a pixel enable needs a full divide period of count_en behind it
   a_cen_needs_en: assert property (@(posedge clk) disable iff (!CR)
      pix_cen_o |-> count_en_i && $past(count_en_i, CLK_DIV - 1));

endmodule

`default_nettype wire

/* verilog/starforce_pkg.sv */
// shared constants and enums; CLK_DIV and PIXELS_PER_BYTE are assumed to be powers of two
`default_nettype none

package starforce_pkg;

   // ========================================
   // timing and data widths
   // ========================================

   // clk cycles per pixel, as the 48 MHz to 6 MHz divide
   localparam int CLK_DIV = 8;

   // pixels held in one bitplane byte
   localparam int PIXELS_PER_BYTE = 8;

   // bitplane byte width
   localparam int BYTE_W = 8;

   // counter widths
   localparam int DIV_W = $clog2(CLK_DIV);
   localparam int PIX_W = $clog2(PIXELS_PER_BYTE);

   // ========================================
   // enums
   // ========================================

   // fetch sequencer states
   typedef enum logic [1:0] {
      SEQ_IDLE  = 2'b00,
      SEQ_PRIME = 2'b01,
      SEQ_RUN   = 2'b10
   } seq_state_t;

   // shifter modes, same codes as the 74194 S1/S0 inputs
   typedef enum logic [1:0] {
      MODE_HOLD = 2'b00,
      MODE_SHL  = 2'b01,
      MODE_SHR  = 2'b10,
      MODE_LOAD = 2'b11
   } shift_mode_t;

   // layer that won the priority check
   typedef enum logic [1:0] {
      LAYER_NONE = 2'b00,
      LAYER_BG   = 2'b01,
      LAYER_FG   = 2'b10
   } layer_t;

endpackage

`default_nettype wire
